// File: hdl/dvi_pkg.sv
// shared TMDS definitions for a DVI-only transmitter, with no HDMI data island or guard band codes
package dvi_pkg;

    // a TMDS symbol is always ten bits wide on every DVI lane
    localparam int symbol_bits = 10;

    // control symbols sent while de is low
    // the suffix is the two control bits as {c1, c0}, so on lane 0 that is {vsync, hsync}
    localparam logic [symbol_bits-1:0] ctrl_code_00 = 10'b1101010100;
    localparam logic [symbol_bits-1:0] ctrl_code_01 = 10'b0010101011;
    localparam logic [symbol_bits-1:0] ctrl_code_10 = 10'b0101010100;
    localparam logic [symbol_bits-1:0] ctrl_code_11 = 10'b1010101011;

    // pattern for the TMDS clock lane
    // shifted out lsb first this gives five high bits followed by five low bits
    // bit 0 of each data symbol leaves together with the first high bit
    localparam logic [symbol_bits-1:0] tmds_clock_pattern = 10'b0000011111;

    // field view of a data symbol, msb first as it sits in the 10-bit word
    // bit 9 says the payload was complemented to pull the running disparity back
    // bit 8 is set for XOR chaining and clear for XNOR chaining
    // bits 7:0 carry the transition minimised byte, possibly complemented
    typedef struct packed
    {
        logic       inverted;
        logic       xor_mode;
        logic [7:0] payload;
    } tmds_data_word_s;

    // one symbol seen two ways
    // control codes are written through raw, data symbols are built through data
    // the serializer only ever looks at raw
    typedef union packed
    {
        logic [symbol_bits-1:0] raw;
        tmds_data_word_s        data;
    } tmds_symbol_u;

endpackage

// File: hdl/dvi_transmitter.sv
// DVI transmitter with single-ended outputs for external buffers; both clocks come from outside
`timescale 1ns/10ps

module dvi_transmitter
(
    input  logic       clk_pixel,
    input  logic       clk_pixel_x10,
    input  logic       rst_n,
    input  logic       de,
    input  logic       hsync,
    input  logic       vsync,
    input  logic [7:0] red,
    input  logic [7:0] green,
    input  logic [7:0] blue,
    output logic [2:0] tmds,
    output logic       tmds_clock
);
    import dvi_pkg::*;

    // one registered symbol per lane from the encoders
    tmds_symbol_u symbol0;
    tmds_symbol_u symbol1;
    tmds_symbol_u symbol2;
    // lane 0 control bits as {c1, c0}
    logic [1:0] ctrl_blue;

    // DVI carries the syncs on lane 0 only and puts vsync on c1 and hsync on c0
    assign ctrl_blue = {vsync, hsync};

    // lane 0 carries blue with the syncs
    tmds_encoder u_encoder_blue
    (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .de        (de),
        .ctrl      (ctrl_blue),
        .pixel     (blue),
        .symbol    (symbol0)
    );

    // lane 1 carries green and its control lines stay low because DVI leaves them unused
    tmds_encoder u_encoder_green
    (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .de        (de),
        .ctrl      (2'b00),
        .pixel     (green),
        .symbol    (symbol1)
    );

    // lane 2 carries red and its control lines stay low as on lane 1
    tmds_encoder u_encoder_red
    (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .de        (de),
        .ctrl      (2'b00),
        .pixel     (red),
        .symbol    (symbol2)
    );

    // tmds[0] carries blue, tmds[1] green and tmds[2] red
    // the rising edge of tmds_clock marks bit 0 of each symbol on all three lanes
    tmds_serializer u_serializer
    (
        .clk_pixel     (clk_pixel),
        .clk_pixel_x10 (clk_pixel_x10),
        .rst_n         (rst_n),
        .symbol0       (symbol0),
        .symbol1       (symbol1),
        .symbol2       (symbol2),
        .tmds          (tmds),
        .tmds_clock    (tmds_clock)
    );

endmodule

// File: hdl/tmds_encoder.sv
// one TMDS channel encoder, output registered on clk_pixel; de is assumed to come from a DVI timing source
`timescale 1ns/10ps

module tmds_encoder
(
    input  logic                  clk_pixel,
    input  logic                  rst_n,
    input  logic                  de,
    input  logic [1:0]            ctrl,
    input  logic [7:0]            pixel,
    output dvi_pkg::tmds_symbol_u symbol
);
    import dvi_pkg::*;

    // number of ones in the incoming pixel byte
    logic [3:0] pixel_ones;
    // set when XOR chaining is picked, clear for XNOR
    logic xor_mode;
    // transition minimised byte, before any balancing
    logic [7:0] q_m;
    // ones and zeros in q_m
    logic [3:0] q_m_ones;
    logic [3:0] q_m_zeros;
    // ones minus zeros of q_m, in the range -8 to +8
    logic signed [4:0] q_m_balance;
    // running disparity, ones sent minus zeros sent since the last blanking
    logic signed [4:0] disparity;
    logic signed [4:0] disparity_next;
    // symbol that will be registered on the next clk_pixel edge
    tmds_symbol_u symbol_next;

    // population count of one byte
    function automatic logic [3:0] count_ones(input logic [7:0] value);
        logic [3:0] total;
        total = 4'd0;
        for (int i = 0; i < 8; i++)
        begin
            total = total + {3'b000, value[i]};
        end
        return total;
    endfunction

    // stage 1, transition minimisation
    // XNOR is chosen for bytes heavy in ones, which keeps the number of edges in q_m low
    // a tie at four ones is broken by bit 0 as in the DVI spec
    always_comb
    begin
        pixel_ones = count_ones(pixel);
        xor_mode = !((pixel_ones > 4'd4) || ((pixel_ones == 4'd4) && !pixel[0]));
    end

    // bit 0 passes straight through, every later bit chains on the one below it
    always_comb
    begin
        q_m[0] = pixel[0];
        for (int i = 1; i < 8; i++)
        begin
            if (xor_mode)
            begin
                q_m[i] = q_m[i-1] ^ pixel[i];
            end
            else
            begin
                q_m[i] = ~(q_m[i-1] ^ pixel[i]);
            end
        end
    end

    // balance of the transition minimised byte
    assign q_m_ones = count_ones(q_m);
    assign q_m_zeros = 4'd8 - q_m_ones;
    assign q_m_balance = $signed({1'b0, q_m_ones}) - $signed({1'b0, q_m_zeros});

    // stage 2, DC balancing against the running disparity
    // bits 9 and 8 of the symbol also count toward the disparity, which is why
    // the update adds or removes two depending on xor_mode
    always_comb
    begin
        symbol_next = '0;
        disparity_next = disparity;
        if (!de)
        begin
            // blanking: send a control code and restart the balance count
            disparity_next = 5'sd0;
            case (ctrl)
                2'b00: symbol_next.raw = ctrl_code_00;
                2'b01: symbol_next.raw = ctrl_code_01;
                2'b10: symbol_next.raw = ctrl_code_10;
                default: symbol_next.raw = ctrl_code_11;
            endcase
        end
        else if ((disparity == 5'sd0) || (q_m_balance == 5'sd0))
        begin
            // no bias either way, so bit 9 simply mirrors xor_mode
            symbol_next.data.inverted = !xor_mode;
            symbol_next.data.xor_mode = xor_mode;
            symbol_next.data.payload = xor_mode ? q_m : ~q_m;
            if (xor_mode)
            begin
                disparity_next = disparity + q_m_balance;
            end
            else
            begin
                disparity_next = disparity - q_m_balance;
            end
        end
        else if (((disparity > 5'sd0) && (q_m_balance > 5'sd0)) ||
                 ((disparity < 5'sd0) && (q_m_balance < 5'sd0)))
        begin
            // the byte would push the line further the same way, so complement it
            symbol_next.data.inverted = 1'b1;
            symbol_next.data.xor_mode = xor_mode;
            symbol_next.data.payload = ~q_m;
            disparity_next = disparity + (xor_mode ? 5'sd2 : 5'sd0) - q_m_balance;
        end
        else
        begin
            // the byte already pulls toward zero, send it as it is
            symbol_next.data.inverted = 1'b0;
            symbol_next.data.xor_mode = xor_mode;
            symbol_next.data.payload = q_m;
            disparity_next = disparity - (xor_mode ? 5'sd0 : 5'sd2) + q_m_balance;
        end
    end

    // symbol and disparity move together, one clk_pixel after the inputs are sampled
    always_ff @(posedge clk_pixel or negedge rst_n)
    begin
        if (!rst_n)
        begin
            symbol.raw <= ctrl_code_00;
            disparity <= 5'sd0;
        end
        else
        begin
            symbol <= symbol_next;
            disparity <= disparity_next;
        end
    end

endmodule

// File: hdl/tmds_serializer.sv
// 10:1 TMDS serializer with no vendor primitives; clk_pixel_x10 must be exactly 10x clk_pixel and phase aligned
`timescale 1ns/10ps

module tmds_serializer
(
    input  logic                  clk_pixel,
    input  logic                  clk_pixel_x10,
    input  logic                  rst_n,
    input  dvi_pkg::tmds_symbol_u symbol0,
    input  dvi_pkg::tmds_symbol_u symbol1,
    input  dvi_pkg::tmds_symbol_u symbol2,
    output logic [2:0]            tmds,
    output logic                  tmds_clock
);
    import dvi_pkg::*;

    // flips once per pixel, marking that a new set of symbols is on the inputs
    logic load_toggle;
    // two flop synchroniser of load_toggle in the fast domain
    logic [1:0] toggle_sync;
    // delays the synchronised toggle by a full symbol length
    logic [symbol_bits-1:0] load_chain;
    // one fast cycle pulse, once per pixel
    logic load;
    // the three input symbols gathered so each lane uses the same logic
    tmds_symbol_u symbol_in [3];
    // double registered copies of the symbols in the fast domain
    tmds_symbol_u symbol_meta [3];
    tmds_symbol_u symbol_hold [3];
    // per lane shift registers, bit 0 goes out next
    logic [symbol_bits-1:0] shift [3];
    // rotating copy of the clock pattern
    logic [symbol_bits-1:0] clock_shift;

    assign symbol_in[0] = symbol0;
    assign symbol_in[1] = symbol1;
    assign symbol_in[2] = symbol2;

    // the toggle is launched on the same clk_pixel edge as the encoder symbols
    always_ff @(posedge clk_pixel or negedge rst_n)
    begin
        if (!rst_n)
        begin
            load_toggle <= 1'b0;
        end
        else
        begin
            load_toggle <= !load_toggle;
        end
    end

    // bring the toggle across and run it down the chain, msb in
    always_ff @(posedge clk_pixel_x10 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            toggle_sync <= 2'b00;
            load_chain <= '0;
        end
        else
        begin
            toggle_sync <= {toggle_sync[0], load_toggle};
            load_chain <= {toggle_sync[1], load_chain[symbol_bits-1:1]};
        end
    end

    // an edge between the last two stages fires load just as bit 9 of the
    // previous symbol is leaving the shift register
    assign load = load_chain[1] ^ load_chain[0];

    // symbols are stable for a whole pixel, so two plain flops are enough
    // to settle them well before load samples the second stage
    always_ff @(posedge clk_pixel_x10)
    begin
        for (int lane = 0; lane < 3; lane++)
        begin
            symbol_meta[lane] <= symbol_in[lane];
            symbol_hold[lane] <= symbol_meta[lane];
        end
    end

    // the data and clock registers load on the same pulse, which keeps bit 0 of
    // each symbol in step with the first high bit of tmds_clock
    always_ff @(posedge clk_pixel_x10 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int lane = 0; lane < 3; lane++)
            begin
                shift[lane] <= '0;
            end
            clock_shift <= tmds_clock_pattern;
        end
        else if (load)
        begin
            for (int lane = 0; lane < 3; lane++)
            begin
                shift[lane] <= symbol_hold[lane].raw;
            end
            clock_shift <= tmds_clock_pattern;
        end
        else
        begin
            for (int lane = 0; lane < 3; lane++)
            begin
                shift[lane] <= shift[lane] >> 1;
            end
            // rotate so the clock keeps running even if a load were late
            clock_shift <= {clock_shift[0], clock_shift[symbol_bits-1:1]};
        end
    end

    // output flops give every pin the same clock to output delay
    always_ff @(posedge clk_pixel_x10 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            tmds <= 3'b000;
            tmds_clock <= 1'b0;
        end
        else
        begin
            tmds <= {shift[2][0], shift[1][0], shift[0][0]};
            tmds_clock <= clock_shift[0];
        end
    end

endmodule

// File: sim.f
+incdir+verification
hdl/dvi_pkg.sv
hdl/tmds_encoder.sv
hdl/tmds_serializer.sv
hdl/dvi_transmitter.sv
verification/tb_dvi_transmitter.sv

// File: verification/tmds_reference_model.svh
// include in a module that imports dvi_pkg and declares tmds, tmds_clock and clk_pixel_x10
`ifndef TMDS_REFERENCE_MODEL_SVH
`define TMDS_REFERENCE_MODEL_SVH

// running disparity of the model per lane as ones minus zeros since the last blanking
int model_disparity [3];
// the last tmds_clock value seen by the capture lets a rise span two captures
logic clock_seen;

// encodes one pixel for one lane by the DVI 1.0 TMDS algorithm
task automatic model_encode(input int lane, input logic de_in, input logic [1:0] ctrl_in,
                            input logic [7:0] d, output logic [9:0] q_out);
    logic [8:0] q_m;
    int n1_d;
    int n1_q;
    int n0_q;
    int qm8;
    n1_d = $countones(d);
    q_m[0] = d[0];
    // XNOR is used for bytes with many ones and for a tie at four when bit 0 is clear
    if ((n1_d > 4) || ((n1_d == 4) && (d[0] == 1'b0)))
    begin
        for (int i = 1; i < 8; i++)
        begin
            q_m[i] = q_m[i-1] ~^ d[i];
        end
        q_m[8] = 1'b0;
    end
    else
    begin
        for (int i = 1; i < 8; i++)
        begin
            q_m[i] = q_m[i-1] ^ d[i];
        end
        q_m[8] = 1'b1;
    end
    n1_q = $countones(q_m[7:0]);
    n0_q = 8 - n1_q;
    qm8 = q_m[8];
    if (!de_in)
    begin
        model_disparity[lane] = 0;
        case (ctrl_in)
            2'b00: q_out = ctrl_code_00;
            2'b01: q_out = ctrl_code_01;
            2'b10: q_out = ctrl_code_10;
            default: q_out = ctrl_code_11;
        endcase
    end
    else if ((model_disparity[lane] == 0) || (n1_q == n0_q))
    begin
        q_out = {~q_m[8], q_m[8], (q_m[8] ? q_m[7:0] : ~q_m[7:0])};
        model_disparity[lane] += (qm8 == 1) ? (n1_q - n0_q) : (n0_q - n1_q);
    end
    else if (((model_disparity[lane] > 0) && (n1_q > n0_q)) ||
             ((model_disparity[lane] < 0) && (n0_q > n1_q)))
    begin
        q_out = {1'b1, q_m[8], ~q_m[7:0]};
        model_disparity[lane] += 2 * qm8 + n0_q - n1_q;
    end
    else
    begin
        q_out = {1'b0, q_m[8], q_m[7:0]};
        model_disparity[lane] += n1_q - n0_q - 2 * (1 - qm8);
    end
endtask

// recovers the pixel byte from a received data symbol through its field view
function automatic logic [7:0] decode_symbol(input tmds_symbol_u s);
    logic [7:0] q;
    logic [7:0] d;
    q = s.data.inverted ? ~s.data.payload : s.data.payload;
    d[0] = q[0];
    for (int i = 1; i < 8; i++)
    begin
        d[i] = s.data.xor_mode ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
    end
    return d;
endfunction

// waits up to 40 fast cycles for tmds_clock to rise and then takes ten bits per lane
// outputs change on the rising fast edge, so every bit is sampled on the falling one
task automatic capture_symbol(output logic [9:0] w0, output logic [9:0] w1,
                              output logic [9:0] w2, output logic [9:0] clock_word,
                              output int waited, output logic found);
    found = 1'b0;
    waited = 0;
    while (!found && (waited < 40))
    begin
        @(negedge clk_pixel_x10);
        waited++;
        found = tmds_clock && !clock_seen;
        clock_seen = tmds_clock;
    end
    // bit 0 leaves together with the first high clock bit
    for (int i = 0; i < 10; i++)
    begin
        if (found && (i > 0))
        begin
            @(negedge clk_pixel_x10);
        end
        w0[i] = tmds[0];
        w1[i] = tmds[1];
        w2[i] = tmds[2];
        clock_word[i] = tmds_clock;
    end
    clock_seen = tmds_clock;
endtask

`endif

// File: verification/tb_dvi_transmitter.sv
// directed testbench; the serial latency is assumed constant and is found from the stream
`timescale 1ns/10ps

module tb_dvi_transmitter;
    import dvi_pkg::*;

    logic clk_pixel;
    logic clk_pixel_x10;
    logic rst_n;
    logic de;
    logic hsync;
    logic vsync;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    logic [2:0] tmds;
    logic tmds_clock;

    // expected symbols as {lane2, lane1, lane0} and the pixels as {de, red, green, blue}
    logic [29:0] exp_sym [$];
    logic [24:0] exp_pixel [$];
    int seed;
    int pushed;
    int compared;
    int check_count;
    int error_count;
    int timeout_count;
    // ones minus zeros really sent per lane since the last blanking symbol
    int line_disparity [3];
    // largest disparity magnitude seen on any lane of the received stream
    int line_peak;
    // set once the received stream has lined up with the expected queue
    logic aligned;
    logic stream_stopped;

    `include "tmds_reference_model.svh"

    dvi_transmitter u_dvi_transmitter
    (
        .clk_pixel     (clk_pixel),
        .clk_pixel_x10 (clk_pixel_x10),
        .rst_n         (rst_n),
        .de            (de),
        .hsync         (hsync),
        .vsync         (vsync),
        .red           (red),
        .green         (green),
        .blue          (blue),
        .tmds          (tmds),
        .tmds_clock    (tmds_clock)
    );

    // the fast clock starts high so both clocks rise together every 1000 ns
    initial
    begin
        clk_pixel_x10 = 1'b1;
        clk_pixel = 1'b0;
    end
    always #50 clk_pixel_x10 = ~clk_pixel_x10;
    always #500 clk_pixel = ~clk_pixel;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("CHECK FAILED at %0t: %s expected %0h actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    // drives one pixel per falling clk_pixel edge and records the model's symbols for it
    task automatic drive_pixel(input logic de_in, input logic hs, input logic vs,
                               input logic [7:0] r, input logic [7:0] g, input logic [7:0] b);
        logic [9:0] s0;
        logic [9:0] s1;
        logic [9:0] s2;
        @(negedge clk_pixel);
        de = de_in;
        hsync = hs;
        vsync = vs;
        red = r;
        green = g;
        blue = b;
        model_encode(0, de_in, {vs, hs}, b, s0);
        model_encode(1, de_in, 2'b00, g, s1);
        model_encode(2, de_in, 2'b00, r, s2);
        exp_sym.push_back({s2, s1, s0});
        exp_pixel.push_back({de_in, r, g, b});
        pushed++;
    endtask

    // adds one received symbol to the running disparity of its lane
    task automatic track_line_disparity(input int lane, input logic active,
                                        input logic [9:0] word);
        if (active)
        begin
            line_disparity[lane] += 2 * $countones(word) - 10;
        end
        else
        begin
            line_disparity[lane] = 0;
        end
        if (line_disparity[lane] > line_peak)
        begin
            line_peak = line_disparity[lane];
        end
        if (-line_disparity[lane] > line_peak)
        begin
            line_peak = -line_disparity[lane];
        end
    endtask

    // raw symbols, clock shape and the decoded bytes of one received symbol
    task automatic compare_symbol(input logic [9:0] w0, input logic [9:0] w1,
                                  input logic [9:0] w2, input logic [9:0] clock_word,
                                  input int waited);
        logic [29:0] want;
        logic [24:0] pix;
        if (exp_sym.size() == 0)
        begin
            error_count++;
            $display("error at %0t: a symbol arrived with no driven pixel left for it", $time);
        end
        else
        begin
            want = exp_sym.pop_front();
            pix = exp_pixel.pop_front();
            track_line_disparity(0, pix[24], w0);
            track_line_disparity(1, pix[24], w1);
            track_line_disparity(2, pix[24], w2);
            check_value("tmds_clock", tmds_clock_pattern, clock_word);
            // the first aligned symbol may follow a capture cut short by the first load
            if (compared > 0)
            begin
                check_value("tmds_clock rise spacing", 1, waited);
            end
            check_value("tmds[0]", want[9:0], w0);
            check_value("tmds[1]", want[19:10], w1);
            check_value("tmds[2]", want[29:20], w2);
            if (pix[24])
            begin
                check_value("blue", pix[7:0], decode_symbol(w0));
                check_value("green", pix[15:8], decode_symbol(w1));
                check_value("red", pix[23:16], decode_symbol(w2));
            end
            compared++;
        end
    endtask

    // runs for the whole test and skips symbols until the first expected one shows up
    task automatic monitor_stream();
        logic [9:0] w0;
        logic [9:0] w1;
        logic [9:0] w2;
        logic [9:0] clock_word;
        int waited;
        logic found;
        int skipped;
        skipped = 0;
        while (!stream_stopped)
        begin
            capture_symbol(w0, w1, w2, clock_word, waited, found);
            if (!found)
            begin
                timeout_count++;
                $display("timeout at %0t: tmds_clock did not rise within 40 fast cycles", $time);
                stream_stopped = 1'b1;
            end
            else
            begin
                if (!aligned && (exp_sym.size() > 0) && ({w2, w1, w0} === exp_sym[0]))
                begin
                    aligned = 1'b1;
                end
                if (aligned)
                begin
                    compare_symbol(w0, w1, w2, clock_word, waited);
                end
                else if (skipped == 40)
                begin
                    error_count++;
                    $display("error at %0t: the first expected symbol never appeared", $time);
                    stream_stopped = 1'b1;
                end
                else
                begin
                    skipped++;
                end
            end
        end
    endtask

    // keeps blanking going until every pixel driven so far has been compared
    task automatic wait_for_compare();
        int target;
        int tries;
        target = pushed;
        tries = 0;
        while ((compared < target) && (tries < 20))
        begin
            drive_pixel(1'b0, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00);
            tries++;
        end
        if (compared < target)
        begin
            timeout_count++;
            $display("timeout at %0t: the serial stream fell behind the driven pixels", $time);
        end
    endtask

    // all outputs must stay low while rst_n is held for five fast cycles
    task automatic hold_reset();
        rst_n = 1'b0;
        for (int i = 0; i < 5; i++)
        begin
            @(negedge clk_pixel_x10);
            check_value("tmds", 3'b000, tmds);
            check_value("tmds_clock", 1'b0, tmds_clock);
        end
        rst_n = 1'b1;
    endtask

    // every sync combination is sent with colour values that blanking must ignore
    task automatic sweep_control_codes();
        logic [31:0] rnd;
        for (int c = 0; c < 4; c++)
        begin
            rnd = $random(seed);
            drive_pixel(1'b0, c[0], c[1], rnd[7:0], rnd[15:8], rnd[23:16]);
            drive_pixel(1'b0, c[0], c[1], rnd[15:8], rnd[23:16], rnd[31:24]);
        end
        wait_for_compare();
    endtask

    // distinct bytes rotate over the channels so a swapped lane cannot hide
    task automatic send_fixed_colours();
        drive_pixel(1'b1, 1'b0, 1'b0, 8'h00, 8'hff, 8'h55);
        drive_pixel(1'b1, 1'b0, 1'b0, 8'hff, 8'h55, 8'h80);
        drive_pixel(1'b1, 1'b0, 1'b0, 8'h55, 8'h80, 8'h00);
        drive_pixel(1'b1, 1'b0, 1'b0, 8'h80, 8'h00, 8'hff);
        wait_for_compare();
    endtask

    // a long active run builds up disparity and the blanking pixel after it must clear it
    task automatic random_balance_run();
        logic [31:0] rnd;
        for (int i = 0; i < 200; i++)
        begin
            rnd = $random(seed);
            drive_pixel(1'b1, 1'b0, 1'b0, rnd[7:0], rnd[15:8], rnd[23:16]);
        end
        drive_pixel(1'b0, 1'b1, 1'b0, 8'h00, 8'h00, 8'h00);
        for (int i = 0; i < 20; i++)
        begin
            rnd = $random(seed);
            drive_pixel(1'b1, 1'b0, 1'b0, rnd[7:0], rnd[15:8], rnd[23:16]);
        end
        wait_for_compare();
        // the received lanes must stay DC balanced over the whole run
        check_value("line disparity within 10", 1'b1, (line_peak <= 10));
    endtask

    // short bursts of both kinds run back to back so every boundary is a transition
    task automatic alternate_bursts();
        logic [31:0] rnd;
        for (int round = 0; round < 6; round++)
        begin
            for (int i = 0; i <= (round % 3); i++)
            begin
                drive_pixel(1'b0, round[0], round[1], 8'h00, 8'h00, 8'h00);
            end
            for (int i = 0; i < (2 + round); i++)
            begin
                rnd = $random(seed);
                drive_pixel(1'b1, 1'b0, 1'b0, rnd[7:0], rnd[15:8], rnd[23:16]);
            end
        end
        wait_for_compare();
    endtask

    initial
    begin
        seed = 32'h0d4bd581;
        pushed = 0;
        compared = 0;
        check_count = 0;
        error_count = 0;
        timeout_count = 0;
        aligned = 1'b0;
        stream_stopped = 1'b0;
        clock_seen = 1'b1;
        line_peak = 0;
        de = 1'b0;
        hsync = 1'b0;
        vsync = 1'b0;
        red = 8'h00;
        green = 8'h00;
        blue = 8'h00;
        hold_reset();
        fork
            monitor_stream();
        join_none
        // ctrl_code_11 never comes out of reset, so it marks the start of the stream
        drive_pixel(1'b0, 1'b1, 1'b1, 8'h00, 8'h00, 8'h00);
        sweep_control_codes();
        send_fixed_colours();
        random_balance_run();
        alternate_bursts();
        if (!aligned)
        begin
            error_count++;
            $display("error: the received stream never lined up with the driven pixels");
        end
        $display("checks %0d, mismatches and other errors %0d, timeouts %0d",
                 check_count, error_count, timeout_count);
        if ((error_count == 0) && (timeout_count == 0))
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
